/* source/cache_geom_pkg.sv */
package cache_geom_pkg;

    // fixed geometry, 2-way, 8 sets, 2 words per block
    localparam int WORD_SIZE  = 32;   // bits per word
    localparam int BLOCK_SIZE = 2;    // words per block
    localparam int ASSOC      = 2;    // ways per set
    localparam int N_SETS     = 8;

    // address field widths
    localparam int N_SET_BITS   = $clog2(N_SETS);
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int N_TAG_BITS   = WORD_SIZE - N_SET_BITS - N_BLOCK_BITS - 2; // 2 byte bits

    typedef logic [WORD_SIZE-1:0]     word_t;
    typedef logic [N_TAG_BITS-1:0]    tag_t;
    typedef logic [N_SET_BITS-1:0]    set_idx_t;
    typedef logic [$clog2(ASSOC)-1:0] way_idx_t;
    typedef logic [N_BLOCK_BITS-1:0]  word_idx_t;  // word within block

    // processor address, msb first
    typedef struct packed {
        tag_t      tag_bits;
        set_idx_t  set_bits;
        word_idx_t word_bits;
        logic [1:0] byte_bits;  // ignored, word access only
    } decoded_addr_t;

endpackage

/* source/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

    import cache_geom_pkg::*;

    // controller states
    typedef enum logic [2:0] {
        IDLE,         // serve hits, accept miss or flush
        WRITEBACK,    // dirty victim out to memory
        FETCH,        // refill block, one word per beat
        FLUSH_SCAN,   // look at one set/way per cycle
        FLUSH_WRITE   // dirty block found during scan
    } cache_state_t;

    // beat counter, one extra bit so it can hold BLOCK_SIZE itself
    typedef logic [$clog2(BLOCK_SIZE+1)-1:0] word_cnt_t;

    localparam word_cnt_t BEATS = word_cnt_t'(BLOCK_SIZE);  // beats per block transfer

endpackage

/* source/cache_store.sv */
`timescale 1ns/1ps

module cache_store import cache_geom_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  decoded_addr_t req_addr,
    input  word_t         wdata,
    input  logic          hit_write,
    input  logic          touch,
    input  logic          fill_word,
    input  logic          fill_done,
    input  logic          clean,
    input  word_idx_t     beat,
    input  word_t         fill_data,
    input  set_idx_t      scan_set,
    input  way_idx_t      scan_way,
    input  logic          use_scan,
    output logic          hit,
    output word_t         hit_data,
    output logic          victim_dirty,
    output tag_t          victim_tag,
    output logic          scan_dirty,
    output tag_t          scan_tag,
    output word_t         rd_word
);

    // storage
    logic [ASSOC-1:0] valid [N_SETS];
    logic [ASSOC-1:0] dirty [N_SETS];
    way_idx_t         lru_way [N_SETS];          // most recently used way per set
    tag_t             tag_arr [N_SETS][ASSOC];
    word_t            data_arr [N_SETS][ASSOC][BLOCK_SIZE];

    set_idx_t         req_set;
    logic [ASSOC-1:0] way_hit;
    way_idx_t         hit_way;
    way_idx_t         victim_way;
    set_idx_t         sel_set;                   // target of clean and write-back read
    way_idx_t         sel_way;

    assign req_set    = req_addr.set_bits;
    assign victim_way = ~lru_way[req_set];       // replace the way not used last

    // tag compare across both ways
    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < ASSOC; w++) begin
            way_hit[w] = valid[req_set][w] && (tag_arr[req_set][w] == req_addr.tag_bits);
            if (way_hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_data = data_arr[req_set][hit_way][req_addr.word_bits];

    // victim info for the miss path
    assign victim_dirty = valid[req_set][victim_way] && dirty[req_set][victim_way];
    assign victim_tag   = tag_arr[req_set][victim_way];

    // flush scan view
    assign scan_dirty = dirty[scan_set][scan_way];
    assign scan_tag   = tag_arr[scan_set][scan_way];

    // scan position during flush, else the victim of the current request
    assign sel_set = use_scan ? scan_set : req_set;
    assign sel_way = use_scan ? scan_way : victim_way;
    assign rd_word = data_arr[sel_set][sel_way][beat];  // write-back data

    // valid, dirty and lru bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                valid[s]   <= '0;
                dirty[s]   <= '0;
                lru_way[s] <= '0;
            end
        end else begin
            if (hit_write) begin
                dirty[req_set][hit_way] <= 1'b1;
            end
            if (hit_write || touch) begin
                lru_way[req_set] <= hit_way;
            end
            if (fill_done) begin                 // new block arrives clean
                valid[req_set][victim_way] <= 1'b1;
                dirty[req_set][victim_way] <= 1'b0;
            end
            if (clean) begin
                dirty[sel_set][sel_way] <= 1'b0; // block now matches memory
            end
        end
    end

    // tags and data
    always_ff @(posedge CLK) begin
        if (hit_write) begin
            data_arr[req_set][hit_way][req_addr.word_bits] <= wdata;
        end
        if (fill_word) begin
            data_arr[req_set][victim_way][beat] <= fill_data;  // one word per beat
        end
        if (fill_done) begin
            tag_arr[req_set][victim_way] <= req_addr.tag_bits;
        end
    end

    // a block is never loaded into two ways of a set
    a_one_way_hit: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(way_hit));

    // refill only happens while no request is completing
    a_fill_no_hit_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(fill_word && hit_write));

endmodule

/* source/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import cache_geom_pkg::*, cache_ctrl_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          proc_ren,
    input  logic          proc_wen,
    input  decoded_addr_t req_addr,
    input  logic          flush,
    input  logic          hit,
    input  logic          victim_dirty,
    input  tag_t          victim_tag,
    input  logic          scan_dirty,
    input  tag_t          scan_tag,
    input  word_t         rd_word,
    input  word_t         mem_rdata,
    input  logic          mem_busy,
    output logic          proc_busy,
    output logic          flush_done,
    output logic          mem_ren,
    output logic          mem_wen,
    output word_t         mem_addr,
    output word_t         mem_wdata,
    output logic          hit_write,
    output logic          touch,
    output logic          fill_word,
    output logic          fill_done,
    output logic          clean,
    output logic          use_scan,
    output word_idx_t     beat,
    output word_t         fill_data,
    output set_idx_t      scan_set,
    output way_idx_t      scan_way
);

    cache_state_t state, next_state;
    word_cnt_t    beat_cnt;
    word_cnt_t    beat_next;
    logic         beat_step;   // a memory beat completes
    logic         last_beat;
    logic         scan_step;   // move to next set/way
    logic         scan_last;
    logic         req;

    assign req       = proc_ren || proc_wen;
    assign beat      = beat_cnt[N_BLOCK_BITS-1:0];
    assign beat_next = beat_cnt + 1'b1;
    assign last_beat = (beat_next == BEATS);
    assign fill_data = mem_rdata;   // refill straight from the bus

    // last way of last set
    assign scan_last = (scan_set == set_idx_t'(N_SETS - 1)) &&
                       (scan_way == way_idx_t'(ASSOC - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // beat counter, cleared after the last word of a block
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            beat_cnt <= '0;
        end else if (beat_step) begin
            beat_cnt <= last_beat ? '0 : beat_next;
        end
    end

    // scan counter, way is the low bit, wraps to 0 after the last block
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            scan_set <= '0;
            scan_way <= '0;
        end else if (scan_step) begin
            {scan_set, scan_way} <= {scan_set, scan_way} + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        proc_busy  = 1'b1;
        flush_done = 1'b0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        hit_write  = 1'b0;
        touch      = 1'b0;
        fill_word  = 1'b0;
        fill_done  = 1'b0;
        clean      = 1'b0;
        use_scan   = 1'b0;
        beat_step  = 1'b0;
        scan_step  = 1'b0;

        case (state)
            IDLE: begin
                if (req && hit) begin
                    proc_busy = 1'b0;          // completes this cycle
                    touch     = 1'b1;
                    hit_write = proc_wen;
                end else if (req) begin
                    // miss, dirty victim goes out first
                    next_state = victim_dirty ? WRITEBACK : FETCH;
                end else if (flush) begin
                    next_state = FLUSH_SCAN;   // requests take priority
                end
            end

            WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, req_addr.set_bits, beat, 2'b00};  // victim's own address
                mem_wdata = rd_word;
                beat_step = !mem_busy;
                if (!mem_busy && last_beat) begin
                    clean      = 1'b1;
                    next_state = FETCH;
                end
            end

            FETCH: begin
                mem_ren   = 1'b1;
                mem_addr  = {req_addr.tag_bits, req_addr.set_bits, beat, 2'b00};
                beat_step = !mem_busy;
                fill_word = !mem_busy;
                if (!mem_busy && last_beat) begin
                    fill_done  = 1'b1;         // valid and tag set, request hits next cycle
                    next_state = IDLE;
                end
            end

            FLUSH_SCAN: begin
                use_scan = 1'b1;
                if (scan_dirty) begin
                    next_state = FLUSH_WRITE;
                end else begin
                    scan_step = 1'b1;
                    if (scan_last) begin
                        flush_done = 1'b1;
                        next_state = IDLE;
                    end
                end
            end

            FLUSH_WRITE: begin
                use_scan  = 1'b1;
                mem_wen   = 1'b1;
                mem_addr  = {scan_tag, scan_set, beat, 2'b00};
                mem_wdata = rd_word;
                beat_step = !mem_busy;
                if (!mem_busy && last_beat) begin
                    clean     = 1'b1;
                    scan_step = 1'b1;
                    if (scan_last) begin
                        flush_done = 1'b1;     // dirty block was the last one
                        next_state = IDLE;
                    end else begin
                        next_state = FLUSH_SCAN;
                    end
                end
            end

            default: next_state = IDLE;
        endcase
    end

    // one memory direction at a time
    a_one_mem_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen));

    // flush_done is a single-cycle pulse
    a_flush_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done);

endmodule

/* source/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache import cache_geom_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  flush,
    output logic  flush_done,
    input  logic  proc_ren,
    input  logic  proc_wen,
    input  word_t proc_addr,
    input  word_t proc_wdata,
    output word_t proc_rdata,
    output logic  proc_busy,
    output logic  mem_ren,
    output logic  mem_wen,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_busy
);

    decoded_addr_t req_addr;
    word_t         hit_data;
    logic          hit, victim_dirty, scan_dirty;
    tag_t          victim_tag, scan_tag;
    word_t         rd_word, fill_data;
    logic          hit_write, touch, fill_word, fill_done, clean, use_scan;
    word_idx_t     beat;
    set_idx_t      scan_set;
    way_idx_t      scan_way;

    assign req_addr   = decoded_addr_t'(proc_addr);  // tag | set | word | byte
    assign proc_rdata = hit_data;                    // only meaningful while busy low

    cache_store cache_store_i (
        .CLK, .nRST,
        .req_addr, .wdata (proc_wdata),
        .hit_write, .touch, .fill_word, .fill_done, .clean,
        .beat, .fill_data,
        .scan_set, .scan_way, .use_scan,
        .hit, .hit_data, .victim_dirty, .victim_tag,
        .scan_dirty, .scan_tag, .rd_word
    );

    cache_ctrl cache_ctrl_i (
        .CLK, .nRST,
        .proc_ren, .proc_wen, .req_addr, .flush,
        .hit, .victim_dirty, .victim_tag, .scan_dirty, .scan_tag, .rd_word,
        .mem_rdata, .mem_busy,
        .proc_busy, .flush_done,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata,
        .hit_write, .touch, .fill_word, .fill_done, .clean, .use_scan,
        .beat, .fill_data, .scan_set, .scan_way
    );

endmodule

/* tb/mem_model.sv */
`timescale 1ns/1ps

module mem_model import cache_geom_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  mem_ren,
    input  logic  mem_wen,
    input  word_t mem_addr,
    input  word_t mem_wdata,
    output word_t mem_rdata,
    output logic  mem_busy
);

    localparam int MEM_WORDS = 1024;        // 4 KB window where higher addresses alias

    word_t       mem [MEM_WORDS];
    logic [31:0] rand_state;                // own LCG for beat delays
    logic [31:0] rand_next;
    logic [1:0]  wait_left;                 // busy cycles left in the current beat
    logic        strobe;
    logic [9:0]  word_idx;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign strobe    = mem_ren || mem_wen;
    assign word_idx  = mem_addr[11:2];      // word address inside the window
    assign rand_next = lcg_step(rand_state);
    assign mem_busy  = strobe && (wait_left != 2'd0);

    // data only in the cycle a read beat completes
    assign mem_rdata = (mem_ren && !mem_busy) ? mem[word_idx] : '0;

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= ~word_t'(i * 4);  // preload with the inverted byte address
            end
            rand_state <= 32'd23;
            wait_left  <= 2'd0;
        end else if (strobe) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 1'b1;  // stretch the beat
            end else begin
                // beat completes on this edge
                if (mem_wen) begin
                    mem[word_idx] <= mem_wdata;
                end
                rand_state <= rand_next;
                wait_left  <= rand_next[17:16]; // 0 to 3 busy cycles for the next beat
            end
        end
    end

endmodule

/* tb/l1_cache_tb.sv */
`timescale 1ns/1ps

module l1_cache_tb import cache_geom_pkg::*; ();

    localparam int MEM_WORDS    = 1024;  // same window as the memory model
    localparam int WAIT_LIMIT   = 200;   // cycles per wait loop
    localparam int RESET_CYCLES = 16;
    localparam int FLUSH_WRITES = 12;

    logic  CLK = 1'b0;
    logic  nRST, flush, flush_done;
    logic  proc_ren, proc_wen, proc_busy;
    word_t proc_addr, proc_wdata, proc_rdata;
    logic  mem_ren, mem_wen, mem_busy;
    word_t mem_addr, mem_wdata, mem_rdata;

    word_t       shadow [MEM_WORDS];   // latest value written to each word
    word_t       shadow_at_mem;
    word_t       exp_rdata;
    logic        expect_hit;           // request must finish at once, no memory beat
    logic        reset_phase;
    logic [31:0] rand_state;
    string       test_name;
    int          errors, err_mark, tests_run, tests_failed;
    word_t       watch_block;          // block whose write-back beats are counted
    int          wb_count = 0;

    always #50 CLK = ~CLK;

    l1_cache l1_cache_i (.*);
    mem_model mem_model_i (.*);

    assign shadow_at_mem = shadow[mem_addr[11:2]];

    always @(negedge CLK) begin
        if (mem_wen && !mem_busy && (mem_addr[31:3] == watch_block[31:3])) begin
            wb_count <= wb_count + 1;  // beat lands on the next edge
        end
    end

    a_reset_idle: assert property (@(posedge CLK)
        reset_phase |-> (!mem_ren && !mem_wen && !flush_done && proc_busy))
        else begin
            errors++;
            $display("%s: memory strobe, flush_done or low proc_busy around reset", test_name);
        end

    a_read_data: assert property (@(posedge CLK) disable iff (!nRST)
        (proc_ren && !proc_busy) |-> (proc_rdata == exp_rdata))
        else begin
            errors++;
            $display("Error: %s: expected %h, actual %h", test_name,
                     $sampled(exp_rdata), $sampled(proc_rdata));
        end

    a_hit_no_mem: assert property (@(posedge CLK) disable iff (!nRST)
        (expect_hit && (proc_ren || proc_wen)) |-> (!proc_busy && !mem_ren && !mem_wen))
        else begin
            errors++;
            $display("%s: expected hit stalled or started a memory beat", test_name);
        end

    // every beat written to memory carries the newest value of that word
    a_wb_data: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wen && !mem_busy) |-> (mem_wdata == shadow_at_mem))
        else begin
            errors++;
            $display("Error: %s: expected %h, actual %h", test_name,
                     $sampled(shadow_at_mem), $sampled(mem_wdata));
        end

    a_flush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else begin
            errors++;
            $display("%s: flush_done stayed high for more than one cycle", test_name);
        end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 16;
    endfunction

    // tag | set | word | byte
    function automatic word_t make_addr(input int tag, input int set, input int word);
        return word_t'((tag << (N_SET_BITS + N_BLOCK_BITS + 2)) |
                       (set << (N_BLOCK_BITS + 2)) | (word << 2));
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - err_mark);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    // sample mid-cycle until proc_busy low or flush_done high
    task automatic wait_for(input logic on_flush);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            done = on_flush ? flush_done : !proc_busy;
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("%s: timed out waiting for %s", test_name,
                     on_flush ? "flush_done" : "proc_busy to drop");
        end
    endtask

    // one request, held until the cache completes it
    task automatic access(input logic wr, input word_t addr, input word_t data,
                          input logic hit_only);
        @(posedge CLK);
        proc_ren   <= !wr;
        proc_wen   <= wr;
        proc_addr  <= addr;
        proc_wdata <= data;
        exp_rdata  <= shadow[addr[11:2]];
        expect_hit <= hit_only;
        wait_for(1'b0);
        @(posedge CLK);                 // completing edge
        if (wr) begin
            shadow[addr[11:2]] = data;
        end
        proc_ren   <= 1'b0;
        proc_wen   <= 1'b0;
        expect_hit <= 1'b0;
    endtask

    initial begin
        word_t a, b, c, d;
        int    s2, t, wb_mark;
        nRST        <= 1'b0;
        flush       <= 1'b0;
        proc_ren    <= 1'b0;
        proc_wen    <= 1'b0;
        proc_addr   <= '0;
        proc_wdata  <= '0;
        exp_rdata   <= '0;
        expect_hit  <= 1'b0;
        reset_phase <= 1'b1;
        rand_state  = 32'd23;
        errors      = 0;
        tests_run   = 0;
        tests_failed = 0;
        watch_block = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = ~word_t'(i * 4);  // memory starts at the inverted address
        end

        start_test("reset_state");
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        reset_phase <= 1'b0;            // first cycle after release still checked
        @(posedge CLK);
        end_test();

        start_test("read_miss_fill");
        s2 = int'(next_rand() % N_SETS);
        t  = int'(next_rand() % 64);
        a  = make_addr(t, s2, int'(next_rand() % BLOCK_SIZE));
        access(1'b0, a, '0, 1'b0);      // fill from memory
        access(1'b0, a, '0, 1'b1);
        end_test();

        start_test("write_hit_readback");
        d = (next_rand() << 16) | next_rand();
        access(1'b1, a, d, 1'b1);
        access(1'b0, a, '0, 1'b1);
        access(1'b0, a ^ 32'h4, '0, 1'b1);  // other word, same block
        end_test();

        start_test("dirty_eviction");
        t = int'(next_rand() % 64);
        a = make_addr(t, (s2 + 3) % N_SETS, 0);
        b = make_addr((t + 21) % 64, (s2 + 3) % N_SETS, 1);
        c = make_addr((t + 42) % 64, (s2 + 3) % N_SETS, 0);
        d = (next_rand() << 16) | next_rand();
        watch_block = a;
        wb_mark = wb_count;
        access(1'b1, a, d, 1'b0);       // write miss leaves a dirty
        access(1'b0, b, '0, 1'b0);
        access(1'b0, c, '0, 1'b0);      // a is least recent, goes out
        assert (wb_count - wb_mark == BLOCK_SIZE) else begin
            errors++;
            $display("Error: %s: expected %0d write-back beats, actual %0d",
                     test_name, BLOCK_SIZE, wb_count - wb_mark);
        end
        access(1'b0, a, '0, 1'b0);
        end_test();

        start_test("lru_replacement");
        t = int'(next_rand() % 64);
        a = make_addr(t, (s2 + 5) % N_SETS, 1);
        b = make_addr((t + 21) % 64, (s2 + 5) % N_SETS, 1);
        c = make_addr((t + 42) % 64, (s2 + 5) % N_SETS, 0);
        access(1'b0, a, '0, 1'b0);
        access(1'b0, b, '0, 1'b0);
        access(1'b0, a, '0, 1'b1);      // a most recent
        access(1'b0, c, '0, 1'b0);      // b replaced
        access(1'b0, a, '0, 1'b1);
        end_test();

        start_test("flush");
        repeat (FLUSH_WRITES) begin
            a = word_t'((next_rand() % MEM_WORDS) * 4);
            d = (next_rand() << 16) | next_rand();
            access(1'b1, a, d, 1'b0);
        end
        @(posedge CLK);
        flush <= 1'b1;                  // no request pending
        wait_for(1'b1);
        @(posedge CLK);
        flush <= 1'b0;
        @(posedge CLK);
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem_model_i.mem[i] == shadow[i]) else begin
                errors++;
                $display("Error: %s: expected %h, actual %h at address %h",
                         test_name, shadow[i], mem_model_i.mem[i], i * 4);
            end
        end
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/cache_geom_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_store.sv
source/cache_ctrl.sv
source/l1_cache.sv
tb/mem_model.sv
tb/l1_cache_tb.sv

/* Makefile */
# Verilator build and run for the L1 cache testbench

VERILATOR ?= verilator
TOP       ?= l1_cache_tb
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert

PASS_MSG := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run into $(LOG), search it for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
